// ==== project.f ====
verilog/hough_pkg.sv
verilog/hough_vote_ram.sv
verilog/hough_voter.sv
verilog/lane_accumulator.sv
verilog/lane_averager.sv
verilog/hough_lane_detector.sv
verif/hough_assertions.sv
verif/hough_checker.sv
verif/tb_hough.sv

// ==== run.sh ====
#!/bin/sh
# Builds the Hough lane detector testbench with Verilator and runs it.
# The run counts as passed only when the log holds the pass line.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_hough \
    -f project.f \
    --Mdir obj_dir \
    -o sim_hough

# A stopped simulation still leaves its log for the search below
./obj_dir/sim_hough > sim.log 2>&1 || true
cat sim.log

if grep -qx '\*\* PASS \*\*' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== verif/hough_assertions.sv ====
// Protocol assertions for the Hough lane detector
// Bound to the top level, they watch the handshake and the image address

`timescale 1ns/1ps
`default_nettype none

module hough_assertions (
    input logic                                   clock,
    input logic                                   reset,
    input logic                                   start,
    input logic                                   ready,
    input logic                                   done,
    input logic [hough_pkg::pixel_addr_width-1:0] image_addr
);
    import hough_pkg::*;

    // Done is a single-cycle pulse
    done_single_cycle: assert property (@(posedge clock) disable iff (reset)
        done |=> !done)
        else $error("done stayed high for two cycles");

    // The averager holds ready low through its done cycle
    ready_not_with_done: assert property (@(posedge clock) disable iff (reset)
        !(ready && done))
        else $error("ready and done were high together");

    // Every image read stays inside the 16 by 12 frame
    image_addr_in_frame: assert property (@(posedge clock) disable iff (reset)
        image_addr < pixel_addr_width'(pixel_count))
        else $error("image_addr went past the last pixel");

    // An accepted start moves the voter out of idle at once
    ready_falls_after_start: assert property (@(posedge clock) disable iff (reset)
        (start && ready) |=> !ready)
        else $error("ready stayed high after an accepted start");

endmodule

`default_nettype wire

// ==== verif/hough_checker.sv ====
// Result checker for the Hough lane detector
// Compares the lanes at every done pulse with the predicted result

`timescale 1ns/1ps
`default_nettype none

module hough_checker (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    done,
    input  hough_pkg::lane_result_t lanes,
    input  hough_pkg::lane_result_t expected,
    input  int                      test_id,
    input  int                      frames_started,
    output int                      error_count,
    output int                      done_count
);
    import hough_pkg::*;

    int wrong;

    // Prints a mismatch line for one field and returns 1 when it differs
    function automatic int compare_field(input string name, input int got, input int want);
        if (got != want) begin
            $display("mismatch at time %0t: %s got %0d expected %0d", $time, name, got, want);
            return 1;
        end
        return 0;
    endfunction

    always @(posedge clock) begin
        if (reset) begin
            error_count = 0;
            done_count = 0;
        end else begin
            // Outside the done cycle the result port must read as zero
            if (!done && lanes != '0) begin
                $display("lanes was not zero outside a done cycle at time %0t", $time);
                error_count = error_count + 1;
            end
            if (done) begin
                done_count = done_count + 1;
                if (done_count > frames_started) begin
                    // A done with no frame behind it, such as after an ignored start
                    $display("done pulsed at time %0t with no frame started", $time);
                    error_count = error_count + 1;
                end else begin
                    wrong = 0;
                    wrong += compare_field("lanes.left.rho", $signed(lanes.left.rho),
                                           $signed(expected.left.rho));
                    wrong += compare_field("lanes.left.theta", lanes.left.theta,
                                           expected.left.theta);
                    wrong += compare_field("lanes.right.rho", $signed(lanes.right.rho),
                                           $signed(expected.right.rho));
                    wrong += compare_field("lanes.right.theta", lanes.right.theta,
                                           expected.right.theta);
                    error_count = error_count + wrong;
                    $display("test %0d: %s", test_id, (wrong == 0) ? "ok" : "failed");
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verif/tb_hough.sv ====
// Testbench for the Hough lane detector
// Feeds edge images from a one-cycle memory model and predicts each frame's lanes

`timescale 1ns/1ps
`default_nettype none

module tb_hough;
    import hough_pkg::*;

    // Nine frames follow the reset test and each is bounded by the worst-case frame length
    localparam int frame_count = 9;
    localparam int frame_cycles = pixel_count * 14 + vote_cells + 1 + 68 + 16;
    localparam int timeout_cycles = frame_count * frame_cycles + vote_cells + 100;

    logic clock = 1'b0;
    logic reset;
    logic start;
    logic ready;
    logic done;
    logic [pixel_addr_width-1:0] image_addr;
    logic [pixel_addr_width-1:0] addr_q = '0;
    logic [7:0] image_data = 8'h00;
    lane_result_t lanes;
    lane_result_t expected;
    logic [7:0] image_mem [pixel_count];
    logic [31:0] rng_state;
    int test_id;
    int frames_started;
    int error_count;
    int done_count;
    int handshake_errors;
    int cycles = 0;

    always #4 clock = ~clock;

    // The image memory takes the address at a rising edge and answers at the falling edge
    always @(posedge clock) addr_q <= image_addr;
    always @(negedge clock) image_data <= image_mem[addr_q];

    hough_lane_detector dut0 (
        .clock     (clock),
        .reset     (reset),
        .start     (start),
        .ready     (ready),
        .image_addr(image_addr),
        .image_data(image_data),
        .done      (done),
        .lanes     (lanes)
    );

    hough_checker checker0 (
        .clock         (clock),
        .reset         (reset),
        .done          (done),
        .lanes         (lanes),
        .expected      (expected),
        .test_id       (test_id),
        .frames_started(frames_started),
        .error_count   (error_count),
        .done_count    (done_count)
    );

    bind hough_lane_detector hough_assertions assertions0 (
        .clock(clock), .reset(reset), .start(start), .ready(ready),
        .done(done), .image_addr(image_addr)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // Votes every edge pixel over all angles and averages the peaks per side
    function automatic lane_result_t ref_lanes();
        int votes [rho_range][theta_count];
        int x, y, r, theta;
        int l_rho, l_theta, l_cnt, r_rho, r_theta, r_cnt;
        lane_result_t res;
        l_rho = 0;
        l_theta = 0;
        l_cnt = 0;
        r_rho = 0;
        r_theta = 0;
        r_cnt = 0;
        foreach (votes[i, j]) votes[i][j] = 0;
        for (int p = 0; p < pixel_count; p++) begin
            if (image_mem[p] != 8'h00) begin
                x = p % image_width;
                y = p / image_width;
                for (int t = 0; t < theta_count; t++) begin
                    // Each product is divided and truncated toward zero on its own
                    r = (x * int'(cos_table[t])) / (1 << trig_frac_bits) +
                        (y * int'(sin_table[t])) / (1 << trig_frac_bits);
                    if (votes[r + rho_offset][t] < vote_max) begin
                        votes[r + rho_offset][t] += 1;
                    end
                end
            end
        end
        foreach (votes[i, j]) begin
            theta = j * theta_step;
            if (votes[i][j] >= vote_threshold && theta > 100) begin
                l_rho += i - rho_offset;
                l_theta += theta;
                l_cnt += 1;
            end else if (votes[i][j] >= vote_threshold && theta < 80) begin
                r_rho += i - rho_offset;
                r_theta += theta;
                r_cnt += 1;
            end
        end
        res.left.rho = rho_width'((l_cnt == 0) ? 0 : l_rho / l_cnt);
        res.left.theta = theta_width'((l_cnt == 0) ? 0 : l_theta / l_cnt);
        res.right.rho = rho_width'((r_cnt == 0) ? 0 : r_rho / r_cnt);
        res.right.theta = theta_width'((r_cnt == 0) ? 0 : r_theta / r_cnt);
        return res;
    endfunction

    // The column at x=5 and the diagonal y=x give peaks at 0 and 135 degrees
    task automatic draw_lines();
        for (int p = 0; p < pixel_count; p++) begin
            image_mem[p] = ((p % image_width == 5) || (p % image_width == p / image_width))
                           ? 8'hff : 8'h00;
        end
    endtask

    // About 15 percent of the pixels become edges with a random nonzero byte
    task automatic draw_random();
        for (int p = 0; p < pixel_count; p++) begin
            rng_state = xorshift(rng_state);
            image_mem[p] = (rng_state % 100 < 15) ? {rng_state[15:9], 1'b1} : 8'h00;
        end
    endtask

    // Predicts the frame result and runs one frame through the DUT
    task automatic start_frame(input int id);
        expected = ref_lanes();
        while (!ready) @(negedge clock);
        test_id = id;
        frames_started = frames_started + 1;
        start = 1'b1;
        @(negedge clock);
        start = 1'b0;
        while (done_count < frames_started) @(negedge clock);
    endtask

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        reset = 1'b1;
        start = 1'b0;
        test_id = 1;
        frames_started = 0;
        handshake_errors = 0;
        expected = '0;
        rng_state = 32'd93;
        foreach (image_mem[p]) image_mem[p] = 8'h00;
        repeat (5) @(negedge clock);
        reset = 1'b0;
        // Test 1 sends a start while the vote memory is still being cleared
        @(negedge clock);
        start = 1'b1;
        @(negedge clock);
        start = 1'b0;
        while (!ready) @(negedge clock);
        // A start that had been kept would pull ready low again within these cycles
        repeat (4) @(negedge clock);
        if (done_count == 0 && ready) begin
            $display("test 1: ok");
        end else begin
            $display("test 1: failed, the start sent during the clear was not ignored");
            handshake_errors = handshake_errors + 1;
        end
        start_frame(2);
        draw_lines();
        start_frame(3);
        for (int i = 0; i < 6; i++) begin
            draw_random();
            start_frame(4 + i);
        end
        // Every pixel is an edge, which gives the heaviest vote counts
        foreach (image_mem[p]) image_mem[p] = 8'(p) | 8'h01;
        start_frame(10);
        repeat (2) @(negedge clock);
        $display("tests: 10, done pulses: %0d, errors: %0d", done_count,
                 error_count + handshake_errors);
        if (error_count == 0 && handshake_errors == 0 && done_count == frames_started) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/hough_lane_detector.sv ====
// Hough lane detector top level
// Voter feeds a left and a right lane accumulator, the averager combines them

`timescale 1ns/1ps
`default_nettype none

module hough_lane_detector (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic                                   start,
    output logic                                   ready,
    output logic [hough_pkg::pixel_addr_width-1:0] image_addr,
    input  logic [7:0]                             image_data,
    output logic                                   done,
    output hough_pkg::lane_result_t                lanes
);
    import hough_pkg::*;

    peak_t peak;
    lane_sum_t left_sum, right_sum;
    logic scan_end, busy;

    hough_voter voter0 (
        .clock     (clock),
        .reset     (reset),
        .start     (start),
        .ready     (ready),
        .image_addr(image_addr),
        .image_data(image_data),
        .busy      (busy),
        .peak      (peak),
        .scan_end  (scan_end)
    );

    // Steep left lanes sit above 100 degrees, right lanes below 80
    lane_accumulator #(.theta_low(101), .theta_high(179)) left_lane (
        .clock(clock), .reset(reset), .peak(peak), .scan_end(scan_end), .sum(left_sum)
    );

    lane_accumulator #(.theta_low(0), .theta_high(79)) right_lane (
        .clock(clock), .reset(reset), .peak(peak), .scan_end(scan_end), .sum(right_sum)
    );

    lane_averager averager0 (
        .clock    (clock),
        .reset    (reset),
        .scan_end (scan_end),
        .left_sum (left_sum),
        .right_sum(right_sum),
        .busy     (busy),
        .done     (done),
        .lanes    (lanes)
    );

endmodule

`default_nettype wire

// ==== verilog/hough_pkg.sv ====
// Shared constants, trig tables and packed structs for the Hough lane finder
// Sizes follow a 16x12 binary edge image and a 12-angle vote grid

`default_nettype none

package hough_pkg;

    // Image geometry
    localparam int image_width = 16;
    localparam int image_height = 12;
    localparam int pixel_count = image_width * image_height;
    localparam int pixel_addr_width = 8;

    // Angles run from 0 to 165 degrees in 15 degree steps
    localparam int theta_count = 12;
    localparam int theta_step = 15;
    localparam int theta_width = 8;
    localparam int theta_index_width = 4;

    // Rho is kept signed and shifted by the offset to index a vote row
    localparam int rho_offset = 20;
    localparam int rho_range = 2 * rho_offset + 1;
    localparam int rho_width = 8;
    localparam int rho_row_width = 6;

    // Vote memory holds one saturating count per (rho row, angle) cell
    localparam int vote_width = 6;
    localparam int vote_max = 63;
    localparam int vote_cells = rho_range * theta_count;
    localparam int vote_addr_width = 9;
    localparam int vote_threshold = 6;

    // Trig entries are scaled by 2^trig_frac_bits
    localparam int trig_frac_bits = 8;
    localparam int trig_width = 10;

    // Lane sum widths
    localparam int count_width = 9;
    localparam int rho_sum_width = 16;
    localparam int theta_sum_width = 16;

    // round(256*cos) and round(256*sin) for each of the 12 angles
    localparam logic signed [trig_width-1:0] cos_table [theta_count] = '{
        10'sd256, 10'sd247, 10'sd222, 10'sd181, 10'sd128, 10'sd66,
        10'sd0, -10'sd66, -10'sd128, -10'sd181, -10'sd222, -10'sd247
    };
    localparam logic signed [trig_width-1:0] sin_table [theta_count] = '{
        10'sd0, 10'sd66, 10'sd128, 10'sd181, 10'sd222, 10'sd247,
        10'sd256, 10'sd247, 10'sd222, 10'sd181, 10'sd128, 10'sd66
    };

    // One line in Hough space, theta in degrees
    typedef struct packed {
        logic signed [rho_width-1:0] rho;
        logic [theta_width-1:0]      theta;
    } line_t;

    typedef struct packed {
        logic  valid;
        line_t line;
    } peak_t;

    typedef struct packed {
        logic signed [rho_sum_width-1:0] rho_sum;
        logic [theta_sum_width-1:0]      theta_sum;
        logic [count_width-1:0]          count;
    } lane_sum_t;

    typedef struct packed {
        line_t left;
        line_t right;
    } lane_result_t;

endpackage

`default_nettype wire

// ==== verilog/hough_vote_ram.sv ====
// Vote memory with one write port and one registered read port
// A read and a write to the same cell in one cycle return the old count

`timescale 1ns/1ps
`default_nettype none

module hough_vote_ram (
    input  logic                                  clock,
    input  logic [hough_pkg::vote_addr_width-1:0] rd_addr,
    output logic [hough_pkg::vote_width-1:0]      rd_data,
    input  logic                                  wr_en,
    input  logic [hough_pkg::vote_addr_width-1:0] wr_addr,
    input  logic [hough_pkg::vote_width-1:0]      wr_data
);
    import hough_pkg::*;

    // One count per (rho row, angle) cell, 492 cells in all
    logic [vote_width-1:0] mem [vote_cells];

    // Writes come from the voter's clear, vote and scan phases
    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read data shows up one cycle after the address
    always_ff @(posedge clock) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== verilog/hough_voter.sv ====
// Hough voter: clears the vote memory, scans the edge image, votes one angle
// per cycle through a three-stage pipeline and then sweeps the memory for peaks

`timescale 1ns/1ps
`default_nettype none

module hough_voter (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic                                   start,
    output logic                                   ready,
    output logic [hough_pkg::pixel_addr_width-1:0] image_addr,
    input  logic [7:0]                             image_data,
    input  logic                                   busy,
    output hough_pkg::peak_t                       peak,
    output logic                                   scan_end
);
    import hough_pkg::*;

    typedef enum logic [2:0] {CLEAR, IDLE, PIXEL, VOTE, SCAN, TAIL} state_t;

    state_t state;
    logic [pixel_addr_width-1:0] pix;
    logic [rho_row_width-1:0] row;
    logic [theta_index_width-1:0] tidx;
    logic edge_pixel, last_pixel, cell_last, advance, issue_valid;
    logic [theta_index_width-1:0] trig_idx;
    logic signed [4:0] x_s, y_s;
    logic signed [15:0] prod_x, prod_y;
    logic s1_valid, s2_valid, scan_valid_q, wr_en_q;
    logic signed [rho_width-1:0] s1_px, s1_py, rho_c;
    logic [theta_index_width-1:0] s1_tidx, scan_tidx_q;
    logic [rho_row_width-1:0] row_c, scan_row_q;
    logic [vote_addr_width-1:0] vote_rd_addr, s2_addr, rd_addr, wr_addr_q;
    logic [vote_width-1:0] rd_data, wr_data_q;

    // Cells are laid out row by row with the angle index as the low part
    function automatic logic [vote_addr_width-1:0] cell_addr(
        input logic [rho_row_width-1:0]     r,
        input logic [theta_index_width-1:0] t
    );
        return vote_addr_width'(r) * vote_addr_width'(theta_count) + vote_addr_width'(t);
    endfunction

    // Divide by 256 and truncate toward zero, so negatives round up
    function automatic logic signed [rho_width-1:0] scale_down(input logic signed [15:0] p);
        logic signed [15:0] q;
        if (p < 0) begin
            q = -((-p) >>> trig_frac_bits);
        end else begin
            q = p >>> trig_frac_bits;
        end
        return rho_width'(q);
    endfunction

    hough_vote_ram vote_ram (
        .clock  (clock),
        .rd_addr(rd_addr),
        .rd_data(rd_data),
        .wr_en  (wr_en_q),
        .wr_addr(wr_addr_q),
        .wr_data(wr_data_q)
    );

    assign ready = (state == IDLE) && !busy;
    assign edge_pixel = (image_data != '0);
    assign last_pixel = (pix == pixel_addr_width'(pixel_count - 1));
    assign cell_last = (row == rho_row_width'(rho_range - 1)) &&
                       (tidx == theta_index_width'(theta_count - 1));
    // The VOTE state ends after the last angle plus two drain cycles
    assign advance = ((state == PIXEL) && !edge_pixel) ||
                     ((state == VOTE) && (tidx == theta_index_width'(theta_count + 1)));

    // The next pixel is requested in the cycle before PIXEL looks at it
    always_comb begin
        if (state == IDLE) begin
            image_addr = '0;
        end else if (advance && !last_pixel) begin
            image_addr = pix + 1'b1;
        end else begin
            image_addr = pix;
        end
    end

    // Stage one takes angle 0 in the PIXEL cycle itself and the rest from VOTE
    assign issue_valid = ((state == PIXEL) && edge_pixel) ||
                         ((state == VOTE) && (tidx < theta_index_width'(theta_count)));
    assign trig_idx = ((state == VOTE) && issue_valid) ? tidx : '0;
    assign x_s = {1'b0, pix[3:0]};
    assign y_s = {1'b0, pix[7:4]};
    assign prod_x = x_s * cos_table[trig_idx];
    assign prod_y = y_s * sin_table[trig_idx];

    // Stage two forms rho and reads the cell
    assign rho_c = s1_px + s1_py;
    assign row_c = rho_row_width'(rho_c + rho_width'(rho_offset));
    assign vote_rd_addr = cell_addr(row_c, s1_tidx);
    assign rd_addr = (state == SCAN) ? cell_addr(row, tidx) : vote_rd_addr;

    // Peaks come straight off the read port one cycle after each scan read
    always_comb begin
        peak.valid = scan_valid_q && (rd_data >= vote_width'(vote_threshold));
        peak.line.rho = rho_width'(scan_row_q) - rho_width'(rho_offset);
        peak.line.theta = theta_width'(scan_tidx_q) * theta_width'(theta_step);
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= CLEAR;
            pix <= '0;
            row <= '0;
            tidx <= '0;
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            scan_valid_q <= 1'b0;
            wr_en_q <= 1'b0;
            scan_end <= 1'b0;
        end else begin
            s1_valid <= issue_valid;
            s2_valid <= s1_valid;
            scan_valid_q <= (state == SCAN);
            // Every clear, vote and scan cell turns into one write a cycle later
            wr_en_q <= (state == CLEAR) || s2_valid || scan_valid_q;
            scan_end <= (state == TAIL);
            case (state)
                CLEAR, SCAN: begin
                    if (tidx == theta_index_width'(theta_count - 1)) begin
                        tidx <= '0;
                        row <= row + 1'b1;
                    end else begin
                        tidx <= tidx + 1'b1;
                    end
                    if (cell_last) begin
                        row <= '0;
                        state <= (state == CLEAR) ? IDLE : TAIL;
                    end
                end
                IDLE: begin
                    if (start && ready) begin
                        pix <= '0;
                        state <= PIXEL;
                    end
                end
                PIXEL, VOTE: begin
                    if (advance) begin
                        tidx <= '0;
                        if (last_pixel) begin
                            state <= SCAN;
                        end else begin
                            pix <= pix + 1'b1;
                            state <= PIXEL;
                        end
                    end else begin
                        // An edge pixel already issued angle 0 in PIXEL
                        tidx <= (state == PIXEL) ? theta_index_width'(1) : tidx + 1'b1;
                        state <= VOTE;
                    end
                end
                // One extra cycle lets the last scan read come back
                TAIL: state <= IDLE;
                default: state <= CLEAR;
            endcase
        end
    end

    // Pipeline and write payload
    always_ff @(posedge clock) begin
        s1_px <= scale_down(prod_x);
        s1_py <= scale_down(prod_y);
        s1_tidx <= trig_idx;
        s2_addr <= vote_rd_addr;
        scan_row_q <= row;
        scan_tidx_q <= tidx;
        if (state == CLEAR) begin
            wr_addr_q <= cell_addr(row, tidx);
            wr_data_q <= '0;
        end else if (s2_valid) begin
            // Stage three increments the count and holds it at the top
            wr_addr_q <= s2_addr;
            wr_data_q <= (rd_data == vote_width'(vote_max)) ? rd_data : rd_data + 1'b1;
        end else begin
            // Scan writes zero behind each read so the next frame starts clean
            wr_addr_q <= cell_addr(scan_row_q, scan_tidx_q);
            wr_data_q <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/lane_accumulator.sv ====
// Lane accumulator: sums rho, theta and a count over the peaks whose angle
// lies inside one theta window, and starts over after each scan

`timescale 1ns/1ps
`default_nettype none

module lane_accumulator #(
    parameter int theta_low = 0,
    parameter int theta_high = 179
) (
    input  logic                 clock,
    input  logic                 reset,
    input  hough_pkg::peak_t     peak,
    input  logic                 scan_end,
    output hough_pkg::lane_sum_t sum
);
    import hough_pkg::*;

    logic in_window;

    // Both window edges are inclusive
    assign in_window = peak.valid &&
                       (peak.line.theta >= theta_width'(theta_low)) &&
                       (peak.line.theta <= theta_width'(theta_high));

    // The scan never produces a peak in the scan_end cycle, so the clear wins
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            sum <= '0;
        end else if (scan_end) begin
            sum <= '0;
        end else if (in_window) begin
            // Rho is sign extended into the wider running sum
            sum.rho_sum <= sum.rho_sum + rho_sum_width'(peak.line.rho);
            sum.theta_sum <= sum.theta_sum + theta_sum_width'(peak.line.theta);
            sum.count <= sum.count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/lane_averager.sv ====
// Lane averager: latches both side sums at scan end and runs one restoring
// divider four times to turn them into the average left and right lanes

`timescale 1ns/1ps
`default_nettype none

module lane_averager (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    scan_end,
    input  hough_pkg::lane_sum_t    left_sum,
    input  hough_pkg::lane_sum_t    right_sum,
    output logic                    busy,
    output logic                    done,
    output hough_pkg::lane_result_t lanes
);
    import hough_pkg::*;

    lane_sum_t left_q, right_q, src;
    lane_result_t result;
    logic active, neg, load_neg, fits;
    logic [1:0] job;
    logic [4:0] step;
    logic [count_width-1:0] divisor, rem, rem_next;
    logic [count_width:0] trial;
    logic [theta_sum_width-1:0] quo, quo_next, quo_final, load_mag;

    // Jobs run as left rho, left theta, right rho, right theta
    // Job 0 loads in the scan_end cycle straight from the accumulator
    always_comb begin
        src = scan_end ? left_sum : (job[1] ? right_q : left_q);
        load_neg = !job[0] && src.rho_sum[rho_sum_width-1];
        if (job[0]) begin
            load_mag = src.theta_sum;
        end else if (load_neg) begin
            load_mag = theta_sum_width'(-src.rho_sum);
        end else begin
            load_mag = theta_sum_width'(src.rho_sum);
        end
        // One restoring step brings down the next dividend bit
        trial = {rem, quo[theta_sum_width-1]};
        fits = (trial >= {1'b0, divisor});
        rem_next = fits ? count_width'(trial - {1'b0, divisor}) : count_width'(trial);
        quo_next = {quo[theta_sum_width-2:0], fits};
        // A side without peaks reports zero
        quo_final = (divisor == '0) ? '0 : quo_next;
    end

    // Each job is one load cycle plus 16 shift cycles, 68 cycles in all
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            active <= 1'b0;
            job <= '0;
            step <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (scan_end) begin
                active <= 1'b1;
                step <= 5'd1;
            end else if (active) begin
                if (step == '0) begin
                    step <= 5'd1;
                end else if (step == 5'(theta_sum_width)) begin
                    step <= '0;
                    // The job index wraps back to 0 after the last division
                    job <= job + 1'b1;
                    if (job == 2'd3) begin
                        active <= 1'b0;
                        done <= 1'b1;
                    end
                end else begin
                    step <= step + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (scan_end) begin
            left_q <= left_sum;
            right_q <= right_sum;
        end
        if (scan_end || (active && step == '0)) begin
            quo <= load_mag;
            rem <= '0;
            neg <= load_neg;
            divisor <= src.count;
        end else if (active) begin
            quo <= quo_next;
            rem <= rem_next;
        end
        // Rho gets its sign back on the way into the result
        if (active && step == 5'(theta_sum_width)) begin
            case (job)
                2'd0: result.left.rho <= neg ? rho_width'(-quo_final) : rho_width'(quo_final);
                2'd1: result.left.theta <= theta_width'(quo_final);
                2'd2: result.right.rho <= neg ? rho_width'(-quo_final) : rho_width'(quo_final);
                default: result.right.theta <= theta_width'(quo_final);
            endcase
        end
    end

    // Busy covers the done cycle so the voter stays not ready until it passes
    assign busy = scan_end || active || done;
    assign lanes = done ? result : '0;

endmodule

`default_nettype wire
